/* rtl/la_pkg.sv */
`default_nettype none

package la_pkg;

   // one bit per channel in a sample
   localparam int SAMPLE_W = 8;

   // test pattern register
   localparam logic [7:0] LFSR_SEED = 8'h01;  // any nonzero value works
   localparam logic [7:0] LFSR_TAPS = 8'hB8;  // feedback from bits 7 5 4 3

   // capture controller states
   typedef enum logic [2:0] {
      CAP_IDLE = 3'd0,  // nothing armed yet
      CAP_PRE  = 3'd1,  // filling pre-trigger history
      CAP_WAIT = 3'd2,  // history full and looking for trigger
      CAP_POST = 3'd3,  // trigger seen and filling the rest
      CAP_DONE = 3'd4   // record complete with start_addr valid
   } cap_state_e;

   // condition on the selected channel
   typedef enum logic [1:0] {
      TRIG_RISE = 2'd0,
      TRIG_FALL = 2'd1,
      TRIG_HIGH = 2'd2,
      TRIG_LOW  = 2'd3
   } trig_mode_e;

   // sample strobe every 1, 2, 4 or 8 clocks
   typedef enum logic [1:0] {
      RATE_DIV1 = 2'd0,
      RATE_DIV2 = 2'd1,
      RATE_DIV4 = 2'd2,
      RATE_DIV8 = 2'd3
   } rate_e;

endpackage

`default_nettype wire

/* rtl/freq_div.sv */
`timescale 1ns/1ns
`default_nettype none

module freq_div (
   input  wire                  sys_clk,
   input  wire                  i_arst_n,
   input  wire la_pkg::rate_e   i_rate,
   output logic                 o_sample_en
);

   import la_pkg::*;

   rate_e        rate_q;    // rate seen last cycle
   logic [2:0]   cnt;       // clocks since last strobe
   logic [2:0]   term;      // divisor minus one
   logic [2:0]   cnt_base;
   logic         rate_chg;

   always_comb begin
      case (i_rate)
         RATE_DIV1: term = 3'd0;
         RATE_DIV2: term = 3'd1;
         RATE_DIV4: term = 3'd3;
         RATE_DIV8: term = 3'd7;
         default:   term = 3'd0;
      endcase
   end

   // a new rate counts from zero in this very cycle
   assign rate_chg = (i_rate != rate_q);
   assign cnt_base = rate_chg ? 3'd0 : cnt;

   always_ff @(posedge sys_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rate_q      <= RATE_DIV1;
         cnt         <= 3'd0;
         o_sample_en <= 1'b0;
      end else begin
         rate_q <= i_rate;
         if (cnt_base == term) begin
            cnt         <= 3'd0;
            o_sample_en <= 1'b1;  // one clock wide
         end else begin
            cnt         <= cnt_base + 3'd1;
            o_sample_en <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/lfsr.sv */
`timescale 1ns/1ns
`default_nettype none

module lfsr (
   input  wire          sys_clk,
   input  wire          i_arst_n,
   input  wire          i_step,
   output logic [7:0]   o_data
);

   import la_pkg::*;

   logic [7:0]   lfsr_q;
   logic         fb_bit;

   // fibonacci form with xor of tapped bits entering at bit 0
   assign fb_bit = ^(lfsr_q & LFSR_TAPS);
   assign o_data = lfsr_q;

   always_ff @(posedge sys_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         lfsr_q <= LFSR_SEED;
      end else if (i_step) begin
         lfsr_q <= {lfsr_q[6:0], fb_bit};  // one step per sample strobe
      end
   end

   // all-zero lockup state is never reachable from the seed
   a_never_zero: assert property (@(posedge sys_clk) disable iff (!i_arst_n)
      lfsr_q != 8'h00);

endmodule

`default_nettype wire

/* rtl/sample_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_ctrl #(
   parameter int DEPTH = 1024,
   parameter int AW    = 10
) (
   input  wire                          sys_clk,
   input  wire                          i_arst_n,
   input  wire                          i_sample_en,
   input  wire                          i_arm,
   input  wire [la_pkg::SAMPLE_W-1:0]   i_data,
   input  wire [2:0]                    i_chn_sel,
   input  wire la_pkg::trig_mode_e      i_trig_mode,
   input  wire [AW-1:0]                 i_pre_num,
   output logic                         o_wr_en,
   output logic [AW-1:0]                o_wr_addr,
   output logic [la_pkg::SAMPLE_W-1:0]  o_wr_data,
   output logic [AW-1:0]                o_start_addr,
   output logic                         o_finished,
   output logic                         o_busy
);

   import la_pkg::*;

   cap_state_e      state;
   logic [AW-1:0]   wr_ptr;      // free running around the ring
   logic [AW-1:0]   pre_cnt;     // history samples written so far
   logic [AW-1:0]   post_cnt;    // samples written after trigger
   logic [AW-1:0]   pre_q;       // config held for the whole record
   logic [2:0]      chn_q;
   trig_mode_e      mode_q;
   logic            prev_bit;    // channel bit of last written sample
   logic            cur_bit;
   logic            trig_hit;
   logic [AW-1:0]   post_last;   // final value of post_cnt
   logic            no_post;

   // trigger channel of the incoming sample
   assign cur_bit = i_data[chn_q];

   always_comb begin
      case (mode_q)
         TRIG_RISE: trig_hit = cur_bit & ~prev_bit;
         TRIG_FALL: trig_hit = ~cur_bit & prev_bit;
         TRIG_HIGH: trig_hit = cur_bit;
         TRIG_LOW:  trig_hit = ~cur_bit;
         default:   trig_hit = 1'b0;
      endcase
   end

   // DEPTH - pre_num - 1 samples follow the trigger
   assign post_last = AW'(DEPTH - 2) - pre_q;
   assign no_post   = (pre_q == AW'(DEPTH - 1));  // trigger is the newest sample

   assign o_busy    = (state == CAP_PRE) || (state == CAP_WAIT) || (state == CAP_POST);
   assign o_wr_en   = o_busy & i_sample_en;  // one write per strobe
   assign o_wr_addr = wr_ptr;
   assign o_wr_data = i_data;

   always_ff @(posedge sys_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state        <= CAP_IDLE;
         wr_ptr       <= '0;
         pre_cnt      <= '0;
         post_cnt     <= '0;
         pre_q        <= '0;
         chn_q        <= 3'd0;
         mode_q       <= TRIG_RISE;
         prev_bit     <= 1'b0;
         o_start_addr <= '0;
         o_finished   <= 1'b0;
      end else begin
         o_finished <= 1'b0;

         // pointer and edge history follow every write
         if (o_wr_en) begin
            wr_ptr   <= wr_ptr + 1'b1;
            prev_bit <= cur_bit;
         end

         case (state)
            CAP_IDLE, CAP_DONE: begin
               if (i_arm) begin
                  state   <= CAP_PRE;
                  pre_q   <= i_pre_num;    // latched so host may change inputs
                  chn_q   <= i_chn_sel;
                  mode_q  <= i_trig_mode;
                  pre_cnt <= '0;
               end
            end

            CAP_PRE: begin
               if (i_sample_en) begin
                  pre_cnt <= pre_cnt + 1'b1;
                  if (pre_cnt == pre_q - 1'b1) begin
                     state <= CAP_WAIT;  // history full
                  end
               end
            end

            CAP_WAIT: begin
               // older history keeps being overwritten until the trigger
               if (i_sample_en && trig_hit) begin
                  o_start_addr <= wr_ptr - pre_q;  // wraps mod DEPTH
                  post_cnt     <= '0;
                  if (no_post) begin
                     state      <= CAP_DONE;
                     o_finished <= 1'b1;
                  end else begin
                     state <= CAP_POST;
                  end
               end
            end

            CAP_POST: begin
               if (i_sample_en) begin
                  post_cnt <= post_cnt + 1'b1;
                  if (post_cnt == post_last) begin
                     state      <= CAP_DONE;
                     o_finished <= 1'b1;  // clock after the last write
                  end
               end
            end

            default: state <= CAP_IDLE;
         endcase
      end
   end

   // finished follows the last write of the record by one clock
   a_finish_after_write: assert property (@(posedge sys_clk) disable iff (!i_arst_n)
      o_finished |-> $past(o_wr_en));

   // finished is a single clock strobe
   a_finished_pulse: assert property (@(posedge sys_clk) disable iff (!i_arst_n)
      o_finished |=> !o_finished);

   // held pre_num stays nonzero for the whole record
   a_pre_num_range: assert property (@(posedge sys_clk) disable iff (!i_arst_n)
      o_busy |-> (pre_q != '0));

endmodule

`default_nettype wire

/* rtl/pulse_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_gen #(
   parameter int HOLDOFF = 16  // needs 2 or more
) (
   input  wire    sys_clk,
   input  wire    i_arst_n,
   input  wire    i_run,
   input  wire    i_continuous,
   input  wire    i_finished,
   output logic   o_arm
);

   localparam int HW = $clog2(HOLDOFF + 1);

   logic            pending;   // re-arm scheduled
   logic [HW-1:0]   hold_cnt;  // counts down to one
   logic            rearm;

   // holdoff expired while continuous is still set
   assign rearm = pending && i_continuous && (hold_cnt == HW'(1));

   always_ff @(posedge sys_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_arm    <= 1'b0;
         pending  <= 1'b0;
         hold_cnt <= '0;
      end else begin
         o_arm <= i_run | rearm;  // run strobe delayed one clock

         if (!i_continuous) begin
            pending <= 1'b0;      // single shot cancels a queued re-arm
         end else if (i_finished) begin
            pending  <= 1'b1;
            hold_cnt <= HW'(HOLDOFF - 1);
         end else if (pending) begin
            if (hold_cnt == HW'(1)) begin
               pending <= 1'b0;   // arm issued this clock
            end else begin
               hold_cnt <= hold_cnt - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/capture_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_buffer #(
   parameter int DEPTH = 1024,
   parameter int AW    = 10
) (
   input  wire                          sys_clk,
   input  wire                          i_wr_en,
   input  wire [AW-1:0]                 i_wr_addr,
   input  wire [la_pkg::SAMPLE_W-1:0]   i_wr_data,
   input  wire [AW-1:0]                 i_start_addr,
   input  wire [AW-1:0]                 i_rd_offset,
   output logic [la_pkg::SAMPLE_W-1:0]  o_rd_data
);

   import la_pkg::*;

   // simple dual port ring with one write and one read per clock
   logic [SAMPLE_W-1:0]   mem [DEPTH];
   logic [AW-1:0]         rd_addr;

   // time order offset to physical slot wrapping mod DEPTH
   assign rd_addr = i_start_addr + i_rd_offset;

   always_ff @(posedge sys_clk) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   // registered read returns old data on a same-address collision
   always_ff @(posedge sys_clk) begin
      o_rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* rtl/la_capture_top.sv */
`timescale 1ns/1ns
`default_nettype none

module la_capture_top #(
   parameter  int DEPTH   = 1024,           // power of two
   parameter  int HOLDOFF = 16,
   localparam int AW      = $clog2(DEPTH)
) (
   input  wire                          sys_clk,
   input  wire                          i_arst_n,
   input  wire                          i_run,
   input  wire                          i_continuous,
   input  wire                          i_src_sel,     // 1 selects the test pattern
   input  wire [la_pkg::SAMPLE_W-1:0]   i_probe,
   input  wire [2:0]                    i_chn_sel,
   input  wire la_pkg::trig_mode_e      i_trig_mode,
   input  wire la_pkg::rate_e           i_rate,
   input  wire [AW-1:0]                 i_pre_num,
   input  wire [AW-1:0]                 i_rd_addr,     // offset in time order
   output wire [la_pkg::SAMPLE_W-1:0]   o_rd_data,
   output wire                          o_busy,
   output wire                          o_finished
);

   import la_pkg::*;

   wire                  sample_en;
   wire [7:0]            lfsr_data;
   wire [SAMPLE_W-1:0]   sample_data;
   wire                  arm;
   wire                  finished;
   wire                  wr_en;
   wire [AW-1:0]         wr_addr;
   wire [SAMPLE_W-1:0]   wr_data;
   wire [AW-1:0]         start_addr;

   // sample source mux
   assign sample_data = i_src_sel ? lfsr_data : i_probe;
   assign o_finished  = finished;

   freq_div u_freq_div (
      .sys_clk     (  sys_clk     ), // input
      .i_arst_n    (  i_arst_n    ), // input
      .i_rate      (  i_rate      ), // input
      .o_sample_en (  sample_en   )  // output
   );

   lfsr u_lfsr (
      .sys_clk  (  sys_clk    ), // input
      .i_arst_n (  i_arst_n   ), // input
      .i_step   (  sample_en  ), // input
      .o_data   (  lfsr_data  )  // output
   );

   pulse_gen #(.HOLDOFF(HOLDOFF)) u_pulse_gen (
      .sys_clk      (  sys_clk       ), // input
      .i_arst_n     (  i_arst_n      ), // input
      .i_run        (  i_run         ), // input
      .i_continuous (  i_continuous  ), // input
      .i_finished   (  finished      ), // input
      .o_arm        (  arm           )  // output
   );

   sample_ctrl #(.DEPTH(DEPTH), .AW(AW)) u_sample_ctrl (
      .sys_clk      (  sys_clk      ), // input
      .i_arst_n     (  i_arst_n     ), // input
      .i_sample_en  (  sample_en    ), // input
      .i_arm        (  arm          ), // input
      .i_data       (  sample_data  ), // input
      .i_chn_sel    (  i_chn_sel    ), // input
      .i_trig_mode  (  i_trig_mode  ), // input
      .i_pre_num    (  i_pre_num    ), // input
      .o_wr_en      (  wr_en        ), // output
      .o_wr_addr    (  wr_addr      ), // output
      .o_wr_data    (  wr_data      ), // output
      .o_start_addr (  start_addr   ), // output
      .o_finished   (  finished     ), // output
      .o_busy       (  o_busy       )  // output
   );

   capture_buffer #(.DEPTH(DEPTH), .AW(AW)) u_capture_buffer (
      .sys_clk      (  sys_clk     ), // input
      .i_wr_en      (  wr_en       ), // input
      .i_wr_addr    (  wr_addr     ), // input
      .i_wr_data    (  wr_data     ), // input
      .i_start_addr (  start_addr  ), // input
      .i_rd_offset  (  i_rd_addr   ), // input
      .o_rd_data    (  o_rd_data   )  // output
   );

endmodule

`default_nettype wire

/* verification/la_capture_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module la_capture_tb;

   import la_pkg::*;

   localparam int DEPTH    = 64;
   localparam int AW       = 6;
   localparam int HOLDOFF  = 16;
   localparam int NROWS    = 11;
   localparam int LIMIT    = NROWS * (8 * (2 * DEPTH + 300) + 200);  // whole-run cycle budget
   localparam int SHOT_WIN = 4 * DEPTH * 8;

   logic sys_clk, i_arst_n, i_run, i_continuous, i_src_sel;
   logic [7:0]      i_probe;
   logic [2:0]      i_chn_sel;
   trig_mode_e      i_trig_mode;
   rate_e           i_rate;
   logic [AW-1:0]   i_pre_num, i_rd_addr;
   logic [7:0]      o_rd_data;
   logic            o_busy, o_finished;

   // stimulus table with one entry per row
   string           row_name  [NROWS];
   logic            row_src   [NROWS];   // 1 = lfsr source
   logic [7:0]      row_probe [NROWS];
   logic [2:0]      row_chn   [NROWS];
   trig_mode_e      row_mode  [NROWS];
   rate_e           row_rate  [NROWS];
   int              row_pre   [NROWS];
   logic            row_cont  [NROWS];
   int              nrows;
   integer          seed;
   int              cycles;
   logic [7:0]      rec [DEPTH];        // record in time order

   la_capture_top #(.DEPTH(DEPTH), .HOLDOFF(HOLDOFF)) la_capture_top_i (
      .sys_clk(sys_clk), .i_arst_n(i_arst_n), .i_run(i_run), .i_continuous(i_continuous),
      .i_src_sel(i_src_sel), .i_probe(i_probe), .i_chn_sel(i_chn_sel),
      .i_trig_mode(i_trig_mode), .i_rate(i_rate), .i_pre_num(i_pre_num),
      .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data), .o_busy(o_busy), .o_finished(o_finished)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;  // 40 ns period
   end

   always @(posedge sys_clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) abort_run("timeout waiting for capture finished");
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sample(input string n, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) abort_run($sformatf("Fail %s expected %02h actual %02h", n, exp, act));
   endtask

   task automatic check_flag(input string n, input logic exp, input logic act);
      if (act !== exp) abort_run($sformatf("Fail %s expected %b actual %b", n, exp, act));
   endtask

   task automatic check_mode(input string n, input trig_mode_e exp, input trig_mode_e act);
      if (act !== exp)
         abort_run($sformatf("Fail %s expected %s actual %s", n, exp.name(), act.name()));
   endtask

   // new bit 0 from old bits 7 5 4 3
   function automatic logic [7:0] lfsr_next(input logic [7:0] v);
      return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
   endfunction

   // condition seen on the channel at the trigger offset
   function automatic trig_mode_e seen_mode(input trig_mode_e want, input logic p, input logic c);
      if ((want == TRIG_RISE || want == TRIG_FALL) && (p != c))
         return c ? TRIG_RISE : TRIG_FALL;
      return c ? TRIG_HIGH : TRIG_LOW;  // level only so an edge row fails here
   endfunction

   task automatic add_row(input string n, input logic src, input logic [2:0] chn,
                          input trig_mode_e m, input rate_e r, input int pre, input logic cont);
      integer rnd;
      rnd = $random(seed);
      row_probe[nrows] = rnd[7:0];
      if (!src) row_probe[nrows][chn] = (m == TRIG_HIGH);  // constant probe meets the level
      row_name[nrows] = n;
      row_src[nrows]  = src;
      row_chn[nrows]  = chn;
      row_mode[nrows] = m;
      row_rate[nrows] = r;
      row_pre[nrows]  = pre;
      row_cont[nrows] = cont;
      nrows++;
   endtask

   task automatic wait_finished();
      @(negedge sys_clk);
      while (!o_finished) @(negedge sys_clk);
   endtask

   task automatic read_record();
      @(negedge sys_clk);
      i_rd_addr = '0;
      for (int k = 0; k < DEPTH; k++) begin
         @(negedge sys_clk);
         rec[k] = o_rd_data;                 // one clock read latency
         i_rd_addr = i_rd_addr + 1'b1;
      end
   endtask

   task automatic check_record(input int r);
      string n;
      int    pre;
      n   = row_name[r];
      pre = row_pre[r];
      for (int k = 0; k < DEPTH; k++) begin
         if (!row_src[r]) begin
            check_sample($sformatf("%s off %0d", n, k), row_probe[r], rec[k]);
         end else begin
            check_flag($sformatf("%s nonzero %0d", n, k), 1'b1, rec[k] != 8'h00);
            if (k > 0) check_sample($sformatf("%s step %0d", n, k), lfsr_next(rec[k-1]), rec[k]);
         end
      end
      check_mode({n, " trigger"}, row_mode[r],
                 seen_mode(row_mode[r], rec[pre-1][row_chn[r]], rec[pre][row_chn[r]]));
   endtask

   task automatic run_row(input int r);
      @(negedge sys_clk);
      i_src_sel    = row_src[r];
      i_probe      = row_probe[r];
      i_chn_sel    = row_chn[r];
      i_trig_mode  = row_mode[r];
      i_rate       = row_rate[r];
      i_pre_num    = row_pre[r][AW-1:0];
      i_continuous = row_cont[r];
      repeat (2) @(negedge sys_clk);        // rate change restarts the divider
      i_run = 1'b1;
      @(negedge sys_clk);
      i_run = 1'b0;
      wait_finished();
      check_flag({row_name[r], " busy after"}, 1'b0, o_busy);
      if (row_cont[r]) begin
         wait_finished();                   // re-armed after holdoff without a run
         i_continuous = 1'b0;               // cancels the queued re-arm
         while (o_busy) @(negedge sys_clk);
      end
      read_record();
      check_record(r);
      if (!row_cont[r]) begin
         repeat (SHOT_WIN) begin
            @(negedge sys_clk);
            check_flag({row_name[r], " second finished"}, 1'b0, o_finished);
         end
      end
   endtask

   initial begin
      cycles = 0;
      nrows = 0;
      seed = 32'h2cdc;
      i_arst_n = 1'b0;
      i_run = 1'b0;
      i_continuous = 1'b0;
      i_src_sel = 1'b0;
      i_probe = 8'h00;
      i_chn_sel = 3'd0;
      i_trig_mode = TRIG_RISE;
      i_rate = RATE_DIV1;
      i_pre_num = 6'd1;
      i_rd_addr = '0;
      //      name              src  chn  mode       rate       pre cont
      add_row("ext_high",       0,   2,   TRIG_HIGH, RATE_DIV1, 10, 0);
      add_row("ext_low",        0,   5,   TRIG_LOW,  RATE_DIV2, 32, 0);
      add_row("lfsr_div1_rise", 1,   0,   TRIG_RISE, RATE_DIV1, 1,  0);
      add_row("lfsr_div2_fall", 1,   3,   TRIG_FALL, RATE_DIV2, 10, 0);
      add_row("lfsr_div4_rise", 1,   7,   TRIG_RISE, RATE_DIV4, 63, 0);
      add_row("lfsr_div8_fall", 1,   1,   TRIG_FALL, RATE_DIV8, 63, 0);
      add_row("lfsr_fall_pre1", 1,   6,   TRIG_FALL, RATE_DIV1, 1,  0);
      add_row("lfsr_rise_pre10",1,   4,   TRIG_RISE, RATE_DIV2, 10, 0);
      add_row("lfsr_high",      1,   5,   TRIG_HIGH, RATE_DIV4, 20, 0);
      add_row("lfsr_low",       1,   2,   TRIG_LOW,  RATE_DIV1, 40, 0);
      add_row("lfsr_cont",      1,   0,   TRIG_RISE, RATE_DIV2, 16, 1);
      repeat (5) begin
         @(negedge sys_clk);
         check_flag("reset busy", 1'b0, o_busy);
         check_flag("reset finished", 1'b0, o_finished);
      end
      i_arst_n = 1'b1;
      repeat (4) begin                      // idle until the first run
         @(negedge sys_clk);
         check_flag("idle busy", 1'b0, o_busy);
         check_flag("idle finished", 1'b0, o_finished);
      end
      for (int r = 0; r < nrows; r++) run_row(r);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* la_capture.f */
rtl/la_pkg.sv
rtl/freq_div.sv
rtl/lfsr.sv
rtl/sample_ctrl.sv
rtl/pulse_gen.sv
rtl/capture_buffer.sv
rtl/la_capture_top.sv
verification/la_capture_tb.sv
